// ==== sim/dmi_vectors.txt ====
// Columns, hex: core_reset op addr wdata exp_rdata exp_status
// op 0 nop, 1 read, 2 write; status 0 success, 2 failed, 3 busy
0 2 04 11111111 00000000 0
0 2 05 22222222 00000000 0
0 2 06 33333333 00000000 0
0 2 07 44444444 00000000 0
0 2 20 a5a5a5a5 00000000 0
0 1 04 00000000 11111111 0
0 1 05 00000000 22222222 0
0 1 06 00000000 33333333 0
0 1 07 00000000 44444444 0
0 1 20 00000000 a5a5a5a5 0
0 1 11 00000000 0dbe0c01 0
0 2 11 deadbeef 00000000 2
0 1 11 00000000 0dbe0c01 0
0 1 3f 00000000 00000000 2
0 2 08 12345678 00000000 2
0 0 00 00000000 00000000 0
1 1 04 00000000 00000000 3
0 1 04 00000000 00000000 0
0 1 20 00000000 00000000 0
0 2 06 cafef00d 00000000 0
0 1 06 00000000 cafef00d 0

// ==== sim.f ====
design/dmi_pkg.sv
design/dm_regs_pkg.sv
design/dmi_fifo_async.sv
design/dmi_cdc.sv
design/dmi_timeout_timer.sv
design/dmi_jtag_ctrl.sv
design/dm_regs.sv
design/dmi_top.sv
sim/tb_clk_gen.sv
sim/tb_dmi_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_dmi_top
FILELIST  ?= sim.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

// ==== sim/tb_dmi_top.sv ====
// Testbench for the DMI transport top level
// Reads access vectors, drives requests on the falling tck edge
// Random response back-pressure, response checks, per-test report
// Watchdog bounds the run
`timescale 1ns/1ns
`default_nettype none

module tb_dmi_top
  import dmi_pkg::*;
();

  localparam int NUM_VECTORS  = 21;
  localparam int VEC_FIELDS   = 6;
  localparam int TCK_PERIOD   = 40;
  localparam int CLK_PERIOD   = 26;
  localparam int RESET_CYCLES = 10;
  // Longest legal wait is the timeout path plus some slack
  localparam int RESP_LIMIT   = DMI_TIMEOUT_CYCLES + 10;
  localparam int WATCHDOG_NS  =
    (NUM_VECTORS * (DMI_TIMEOUT_CYCLES + 40) + RESET_CYCLES) * TCK_PERIOD;

  logic                  tck;
  logic                  clk;
  logic                  trst_n;
  logic                  rst_n;
  logic                  dmi_req_valid;
  logic                  dmi_req_ready;
  dmi_op_e               dmi_req_op;
  logic [DMI_ADDR_W-1:0] dmi_req_addr;
  logic [DMI_DATA_W-1:0] dmi_req_data;
  logic                  dmi_resp_valid;
  logic                  dmi_resp_ready;
  logic [DMI_DATA_W-1:0] dmi_resp_data;
  dmi_status_e           dmi_resp_status;

  // Six words per vector hold core reset, op, addr, wdata, rdata and status
  logic [31:0] vec_mem [NUM_VECTORS * VEC_FIELDS];
  integer      seed;
  int          error_count;
  int          check_count;

  // Unrelated JTAG and core clocks
  tb_clk_gen #(.PERIOD_NS(TCK_PERIOD)) u_tck_gen (.clk_o(tck));
  tb_clk_gen #(.PERIOD_NS(CLK_PERIOD)) u_clk_gen (.clk_o(clk));

  dmi_top uut (
    .tck_i            (tck),
    .trst_ni          (trst_n),
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .dmi_req_valid_i  (dmi_req_valid),
    .dmi_req_ready_o  (dmi_req_ready),
    .dmi_req_op_i     (dmi_req_op),
    .dmi_req_addr_i   (dmi_req_addr),
    .dmi_req_data_i   (dmi_req_data),
    .dmi_resp_valid_o (dmi_resp_valid),
    .dmi_resp_ready_i (dmi_resp_ready),
    .dmi_resp_data_o  (dmi_resp_data),
    .dmi_resp_status_o(dmi_resp_status)
  );

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[FAIL] %0t ns: %s: got %08h, expected %08h", $time, what, actual, expected);
    end
  endtask

  function automatic string op_name(input logic [1:0] op);
    case (op)
      DMI_OP_NOP:   op_name = "nop  ";
      DMI_OP_READ:  op_name = "read ";
      DMI_OP_WRITE: op_name = "write";
      default:      op_name = "?    ";
    endcase
  endfunction

  function automatic string status_name(input logic [1:0] status);
    case (status)
      DMI_SUCCESS: status_name = "success";
      DMI_FAILED:  status_name = "failed";
      DMI_BUSY:    status_name = "busy";
      default:     status_name = "reserved";
    endcase
  endfunction

  // Each vector starts and ends on a falling tck edge
  task automatic run_test(input int idx);
    int          base;
    logic        core_rst;
    logic [1:0]  op;
    logic [6:0]  addr;
    logic [31:0] wdata;
    logic [31:0] exp_data;
    logic [1:0]  exp_status;
    logic [31:0] got_data;
    logic [1:0]  got_status;
    int          stall;
    int          waited;
    int          errors_before;
    logic        accepted;
    base          = idx * VEC_FIELDS;
    core_rst      = vec_mem[base][0];
    op            = vec_mem[base + 1][1:0];
    addr          = vec_mem[base + 2][6:0];
    wdata         = vec_mem[base + 3];
    exp_data      = vec_mem[base + 4];
    exp_status    = vec_mem[base + 5][1:0];
    errors_before = error_count;
    // Core reset level follows the vector flag
    rst_n         = !core_rst;
    dmi_req_valid = 1'b1;
    dmi_req_op    = dmi_op_e'(op);
    dmi_req_addr  = addr;
    dmi_req_data  = wdata;
    // Ready seen here is what the next rising edge uses
    accepted = 1'b0;
    waited   = 0;
    while (!accepted && waited < RESP_LIMIT) begin
      accepted = dmi_req_ready;
      @(negedge tck);
      waited++;
    end
    dmi_req_valid = 1'b0;
    waited = 0;
    while (!dmi_resp_valid && waited < RESP_LIMIT) begin
      @(negedge tck);
      waited++;
    end
    if (!accepted || !dmi_resp_valid) begin
      error_count++;
      $display("Error: test %0d got no response within %0d tck cycles", idx, RESP_LIMIT);
    end else begin
      got_data   = dmi_resp_data;
      got_status = dmi_resp_status;
      check_equal(got_data, exp_data, $sformatf("test %0d response data", idx));
      check_equal(32'(got_status), 32'(exp_status), $sformatf("test %0d status", idx));
      // Nothing new is taken while the response waits
      check_equal(32'(dmi_req_ready), 32'd0, $sformatf("test %0d ready low in response", idx));
      // Busy comes a fixed time after the accept
      if (exp_status == DMI_BUSY) begin
        check_equal(32'(waited), 32'(DMI_TIMEOUT_CYCLES + 2),
                    $sformatf("test %0d timeout latency", idx));
      end
      // Response must not move while ready is held off
      stall = ($random(seed) & 32'h7fff_ffff) % 6;
      repeat (stall) begin
        @(negedge tck);
        check_equal(32'(dmi_resp_valid), 32'd1, $sformatf("test %0d valid held", idx));
        check_equal(dmi_resp_data, got_data, $sformatf("test %0d data held", idx));
        check_equal(32'(dmi_resp_status), 32'(got_status),
                    $sformatf("test %0d status held", idx));
      end
      dmi_resp_ready = 1'b1;
      @(negedge tck);
      dmi_resp_ready = 1'b0;
      check_equal(32'(dmi_resp_valid), 32'd0, $sformatf("test %0d valid after transfer", idx));
      check_equal(32'(dmi_req_ready), 32'd1, $sformatf("test %0d back to idle", idx));
    end
    $display("test %2d: %s addr %02h stall %0d -> data %08h %-8s %s", idx, op_name(op), addr,
             stall, dmi_resp_data, status_name(got_status),
             (error_count == errors_before) ? "ok" : "mismatch");
  endtask

  initial begin : stimulus
    seed           = 32'hf68c1bb4;
    error_count    = 0;
    check_count    = 0;
    trst_n         = 1'b0;
    rst_n          = 1'b0;
    dmi_req_valid  = 1'b0;
    dmi_req_op     = DMI_OP_NOP;
    dmi_req_addr   = '0;
    dmi_req_data   = '0;
    dmi_resp_ready = 1'b0;
    $readmemh("sim/dmi_vectors.txt", vec_mem);
    repeat (RESET_CYCLES) @(negedge tck);
    trst_n = 1'b1;
    rst_n  = 1'b1;
    // Idle outputs straight after reset
    check_equal(32'(dmi_req_ready), 32'd1, "request ready after reset");
    check_equal(32'(dmi_resp_valid), 32'd0, "response valid after reset");
    for (int i = 0; i < NUM_VECTORS; i++) begin
      run_test(i);
    end
    $display("%0d tests, %0d checks, %0d errors", NUM_VECTORS, check_count, error_count);
    if (error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Error: the run timed out after %0d ns", WATCHDOG_NS);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/tb_clk_gen.sv ====
// Testbench clock generator
// Free-running clock, period set in ns by a parameter
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS = 40
) (
  output logic clk_o
);

  initial clk_o = 1'b0;

  // Half period per phase, period kept even by the caller
  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== design/dmi_top.sv ====
// DMI transport top level
// JTAG-side controller and timeout timer in the tck domain
// Clock crossing and debug register file on the core side
`timescale 1ns/1ns
`default_nettype none

module dmi_top
  import dmi_pkg::*;
(
  input  logic                  tck_i,
  input  logic                  trst_ni,
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Request channel
  input  logic                  dmi_req_valid_i,
  output logic                  dmi_req_ready_o,
  input  dmi_op_e               dmi_req_op_i,
  input  logic [DMI_ADDR_W-1:0] dmi_req_addr_i,
  input  logic [DMI_DATA_W-1:0] dmi_req_data_i,
  // Response channel
  output logic                  dmi_resp_valid_o,
  input  logic                  dmi_resp_ready_i,
  output logic [DMI_DATA_W-1:0] dmi_resp_data_o,
  output dmi_status_e           dmi_resp_status_o
);

  // Controller to crossing
  dmi_req_t  cdc_req;
  logic      cdc_req_valid;
  logic      cdc_req_ready;
  dmi_resp_t cdc_resp;
  logic      cdc_resp_valid;
  logic      cdc_resp_ready;
  logic      cdc_clear;

  // Controller to timer
  logic tmr_start;
  logic tmr_en;
  logic tmr_expired;

  // Crossing to register file
  logic      core_rst_n;
  dmi_req_t  core_req;
  logic      core_req_valid;
  logic      core_req_ready;
  dmi_resp_t core_resp;
  logic      core_resp_valid;
  logic      core_resp_ready;

  dmi_jtag_ctrl u_jtag_ctrl (
    .tck_i            (tck_i),
    .trst_ni          (trst_ni),
    .dmi_req_valid_i  (dmi_req_valid_i),
    .dmi_req_ready_o  (dmi_req_ready_o),
    .dmi_req_op_i     (dmi_req_op_i),
    .dmi_req_addr_i   (dmi_req_addr_i),
    .dmi_req_data_i   (dmi_req_data_i),
    .dmi_resp_valid_o (dmi_resp_valid_o),
    .dmi_resp_ready_i (dmi_resp_ready_i),
    .dmi_resp_data_o  (dmi_resp_data_o),
    .dmi_resp_status_o(dmi_resp_status_o),
    .cdc_req_o        (cdc_req),
    .cdc_req_valid_o  (cdc_req_valid),
    .cdc_req_ready_i  (cdc_req_ready),
    .cdc_resp_i       (cdc_resp),
    .cdc_resp_valid_i (cdc_resp_valid),
    .cdc_resp_ready_o (cdc_resp_ready),
    .cdc_clear_o      (cdc_clear),
    .tmr_start_o      (tmr_start),
    .tmr_en_o         (tmr_en),
    .tmr_expired_i    (tmr_expired)
  );

  dmi_timeout_timer u_timeout_timer (
    .tck_i    (tck_i),
    .trst_ni  (trst_ni),
    .start_i  (tmr_start),
    .en_i     (tmr_en),
    .expired_o(tmr_expired)
  );

  dmi_cdc u_cdc (
    .tck_i            (tck_i),
    .trst_ni          (trst_ni),
    .jtag_req_i       (cdc_req),
    .jtag_req_valid_i (cdc_req_valid),
    .jtag_req_ready_o (cdc_req_ready),
    .jtag_resp_o      (cdc_resp),
    .jtag_resp_valid_o(cdc_resp_valid),
    .jtag_resp_ready_i(cdc_resp_ready),
    .jtag_clear_i     (cdc_clear),
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .core_rst_no      (core_rst_n),
    .core_req_o       (core_req),
    .core_req_valid_o (core_req_valid),
    .core_req_ready_i (core_req_ready),
    .core_resp_i      (core_resp),
    .core_resp_valid_i(core_resp_valid),
    .core_resp_ready_o(core_resp_ready)
  );

  // Register file runs from the sequenced core reset
  dm_regs u_dm_regs (
    .clk_i       (clk_i),
    .rst_ni      (core_rst_n),
    .req_i       (core_req),
    .req_valid_i (core_req_valid),
    .req_ready_o (core_req_ready),
    .resp_o      (core_resp),
    .resp_valid_o(core_resp_valid),
    .resp_ready_i(core_resp_ready)
  );

endmodule

`default_nettype wire

// ==== design/dm_regs.sv ====
// Core-side debug register file
// Data0 to data3 and scratch, read/write
// Read-only ID word, failed status for bad accesses
// One response register, blocks new requests while held
`timescale 1ns/1ns
`default_nettype none

module dm_regs
  import dmi_pkg::*;
  import dm_regs_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  dmi_req_t  req_i,
  input  logic      req_valid_i,
  output logic      req_ready_o,
  output dmi_resp_t resp_o,
  output logic      resp_valid_o,
  input  logic      resp_ready_i
);

  logic [DMI_DATA_W-1:0] data_q [4];
  logic [DMI_DATA_W-1:0] scratch_q;
  logic                  resp_valid_q;
  dmi_resp_t             resp_q;
  dmi_resp_t             resp_d;
  logic                  req_fire;
  logic                  is_write;
  logic                  addr_hit;
  logic                  addr_ro;
  logic                  is_data;
  logic                  wr_en;
  logic [1:0]            data_idx;
  logic [DMI_DATA_W-1:0] rd_value;

  assign req_ready_o = !resp_valid_q;
  assign req_fire    = req_valid_i && req_ready_o;
  assign is_write    = (req_i.op == DMI_OP_WRITE);
  // Data registers are aligned so the low address bits index them
  assign data_idx    = req_i.addr[1:0];

  // Address decode and read mux
  always_comb begin
    addr_hit = 1'b1;
    addr_ro  = 1'b0;
    is_data  = 1'b0;
    rd_value = '0;
    case (req_i.addr)
      DM_ADDR_DATA0, DM_ADDR_DATA1, DM_ADDR_DATA2, DM_ADDR_DATA3: begin
        is_data  = 1'b1;
        rd_value = data_q[data_idx];
      end
      DM_ADDR_SCRATCH: rd_value = scratch_q;
      DM_ADDR_ID: begin
        addr_ro  = 1'b1;
        rd_value = DM_ID_VALUE;
      end
      default: addr_hit = 1'b0;
    endcase
  end

  // Failed accesses return zero data, writes return zero too
  always_comb begin
    resp_d.data   = '0;
    resp_d.status = DMI_SUCCESS;
    if (!addr_hit || (is_write && addr_ro)) begin
      resp_d.status = DMI_FAILED;
    end else if (req_i.op == DMI_OP_READ) begin
      resp_d.data = rd_value;
    end
  end

  assign wr_en = req_fire && is_write && addr_hit && !addr_ro;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_q    <= '{default: '0};
      scratch_q <= '0;
    end else if (wr_en) begin
      if (is_data) begin
        data_q[data_idx] <= req_i.data;
      end else begin
        // Only writable target left
        scratch_q <= req_i.data;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_q <= 1'b0;
    end else if (req_fire) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      resp_q <= resp_d;
    end
  end

  assign resp_o       = resp_q;
  assign resp_valid_o = resp_valid_q;

endmodule

`default_nettype wire

// ==== design/dmi_jtag_ctrl.sv ====
// JTAG-side DMI access controller
// Takes one request, sends it through the crossing and waits
// Answers busy and clears the crossing when the timer runs out
// Nop requests are answered locally
`timescale 1ns/1ns
`default_nettype none

module dmi_jtag_ctrl
  import dmi_pkg::*;
(
  input  logic                  tck_i,
  input  logic                  trst_ni,
  // Outside request channel
  input  logic                  dmi_req_valid_i,
  output logic                  dmi_req_ready_o,
  input  dmi_op_e               dmi_req_op_i,
  input  logic [DMI_ADDR_W-1:0] dmi_req_addr_i,
  input  logic [DMI_DATA_W-1:0] dmi_req_data_i,
  // Outside response channel
  output logic                  dmi_resp_valid_o,
  input  logic                  dmi_resp_ready_i,
  output logic [DMI_DATA_W-1:0] dmi_resp_data_o,
  output dmi_status_e           dmi_resp_status_o,
  // Crossing
  output dmi_req_t              cdc_req_o,
  output logic                  cdc_req_valid_o,
  input  logic                  cdc_req_ready_i,
  input  dmi_resp_t             cdc_resp_i,
  input  logic                  cdc_resp_valid_i,
  output logic                  cdc_resp_ready_o,
  output logic                  cdc_clear_o,
  // Timeout timer
  output logic                  tmr_start_o,
  output logic                  tmr_en_o,
  input  logic                  tmr_expired_i
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SEND,
    ST_WAIT,
    ST_CLEAR,
    ST_RESP
  } state_e;

  state_e    state_q;
  state_e    state_d;
  dmi_req_t  req_q;
  dmi_resp_t resp_q;
  dmi_resp_t resp_d;
  logic      req_fire;

  assign dmi_req_ready_o = (state_q == ST_IDLE);
  assign req_fire        = dmi_req_valid_i && dmi_req_ready_o;

  assign cdc_req_o       = req_q;
  assign cdc_req_valid_o = (state_q == ST_SEND);
  // Always sink responses, only WAIT keeps one, late ones are dropped
  assign cdc_resp_ready_o = 1'b1;
  assign cdc_clear_o      = (state_q == ST_CLEAR);

  // Budget covers both getting the request across and the answer
  assign tmr_start_o = req_fire;
  assign tmr_en_o    = (state_q == ST_SEND) || (state_q == ST_WAIT);

  assign dmi_resp_valid_o  = (state_q == ST_RESP);
  assign dmi_resp_data_o   = resp_q.data;
  assign dmi_resp_status_o = resp_q.status;

  always_comb begin
    state_d = state_q;
    resp_d  = resp_q;
    case (state_q)
      ST_IDLE: begin
        if (req_fire) begin
          if (dmi_req_op_i == DMI_OP_NOP) begin
            resp_d.data   = '0;
            resp_d.status = DMI_SUCCESS;
            state_d       = ST_RESP;
          end else begin
            state_d = ST_SEND;
          end
        end
      end
      ST_SEND: begin
        if (cdc_req_ready_i) begin
          state_d = ST_WAIT;
        end else if (tmr_expired_i) begin
          state_d = ST_CLEAR;
        end
      end
      ST_WAIT: begin
        // A response in the same cycle as expiry still wins
        if (cdc_resp_valid_i) begin
          resp_d  = cdc_resp_i;
          state_d = ST_RESP;
        end else if (tmr_expired_i) begin
          state_d = ST_CLEAR;
        end
      end
      ST_CLEAR: begin
        resp_d.data   = '0;
        resp_d.status = DMI_BUSY;
        state_d       = ST_RESP;
      end
      ST_RESP: begin
        if (dmi_resp_ready_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge tck_i or negedge trst_ni) begin
    if (!trst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Payload registers
  always_ff @(posedge tck_i) begin
    resp_q <= resp_d;
    if (req_fire) begin
      req_q.addr <= dmi_req_addr_i;
      req_q.data <= dmi_req_data_i;
      req_q.op   <= dmi_req_op_i;
    end
  end

endmodule

`default_nettype wire

// ==== design/dmi_timeout_timer.sv ====
// Access timeout timer in the tck domain
// Loads the cycle budget on start, counts down while enabled
// Registered expired flag, held until the next start
`timescale 1ns/1ns
`default_nettype none

module dmi_timeout_timer
  import dmi_pkg::*;
(
  input  logic tck_i,
  input  logic trst_ni,
  input  logic start_i,
  input  logic en_i,
  output logic expired_o
);

  logic [DMI_TIMEOUT_W-1:0] count_q;
  logic                     expired_q;

  always_ff @(posedge tck_i or negedge trst_ni) begin
    if (!trst_ni) begin
      count_q   <= '0;
      expired_q <= 1'b0;
    end else if (start_i) begin
      count_q   <= DMI_TIMEOUT_W'(DMI_TIMEOUT_CYCLES);
      expired_q <= 1'b0;
    end else if (en_i && (count_q != '0)) begin
      count_q <= count_q - 1'b1;
      // Last step to zero, flag shows after the final enabled edge
      if (count_q == DMI_TIMEOUT_W'(1)) begin
        expired_q <= 1'b1;
      end
    end
  end

  assign expired_o = expired_q;

endmodule

`default_nettype wire

// ==== design/dmi_cdc.sv ====
// DMI clock domain crossing
// Request FIFO from tck to the core clock, response FIFO back
// Core-side reset built from rst_ni and the JTAG-side clear
`timescale 1ns/1ns
`default_nettype none

module dmi_cdc
  import dmi_pkg::*;
(
  // JTAG side
  input  logic      tck_i,
  input  logic      trst_ni,
  input  dmi_req_t  jtag_req_i,
  input  logic      jtag_req_valid_i,
  output logic      jtag_req_ready_o,
  output dmi_resp_t jtag_resp_o,
  output logic      jtag_resp_valid_o,
  input  logic      jtag_resp_ready_i,
  input  logic      jtag_clear_i,
  // Core side
  input  logic      clk_i,
  input  logic      rst_ni,
  output logic      core_rst_no,
  output dmi_req_t  core_req_o,
  output logic      core_req_valid_o,
  input  logic      core_req_ready_i,
  input  dmi_resp_t core_resp_i,
  input  logic      core_resp_valid_i,
  output logic      core_resp_ready_o
);

  logic       clr_rst_n_q;
  logic       core_arst_n;
  logic [1:0] core_rst_sync_q;
  logic       jtag_req_rst_n;

  // Reset enable, low for one tck cycle after a clear
  always_ff @(posedge tck_i or negedge trst_ni) begin
    if (!trst_ni) begin
      clr_rst_n_q <= 1'b0;
    end else begin
      clr_rst_n_q <= !jtag_clear_i;
    end
  end

  // Asserts at once, releases two clk edges after both sources go high
  assign core_arst_n = rst_ni & clr_rst_n_q;

  always_ff @(posedge clk_i or negedge core_arst_n) begin
    if (!core_arst_n) begin
      core_rst_sync_q <= '0;
    end else begin
      core_rst_sync_q <= {core_rst_sync_q[0], 1'b1};
    end
  end

  assign core_rst_no = core_rst_sync_q[1];

  // A clear also drops a request still pending on the tck side,
  // so a stuck access is not replayed once the core comes back
  assign jtag_req_rst_n = trst_ni & clr_rst_n_q;

  dmi_fifo_async #(
    .T(dmi_req_t)
  ) u_req_fifo (
    .clk_wr_i (tck_i),
    .rst_wr_ni(jtag_req_rst_n),
    .wvalid_i (jtag_req_valid_i),
    .wready_o (jtag_req_ready_o),
    .wdata_i  (jtag_req_i),
    .clk_rd_i (clk_i),
    .rst_rd_ni(core_rst_no),
    .rvalid_o (core_req_valid_o),
    .rready_i (core_req_ready_i),
    .rdata_o  (core_req_o)
  );

  dmi_fifo_async #(
    .T(dmi_resp_t)
  ) u_resp_fifo (
    .clk_wr_i (clk_i),
    .rst_wr_ni(core_rst_no),
    .wvalid_i (core_resp_valid_i),
    .wready_o (core_resp_ready_o),
    .wdata_i  (core_resp_i),
    .clk_rd_i (tck_i),
    .rst_rd_ni(trst_ni),
    .rvalid_o (jtag_resp_valid_o),
    .rready_i (jtag_resp_ready_i),
    .rdata_o  (jtag_resp_o)
  );

endmodule

`default_nettype wire

// ==== design/dmi_fifo_async.sv ====
// One-entry asynchronous FIFO for DMI words
// Write side stores the item and raises a request level
// Read side presents the item and answers with an acknowledge level
// Both levels return to zero (four-phase handshake)
// Payload type set by a type parameter
`timescale 1ns/1ns
`default_nettype none

module dmi_fifo_async #(
  parameter type T = logic
) (
  // Write side
  input  logic clk_wr_i,
  input  logic rst_wr_ni,
  input  logic wvalid_i,
  output logic wready_o,
  input  T     wdata_i,
  // Read side
  input  logic clk_rd_i,
  input  logic rst_rd_ni,
  output logic rvalid_o,
  input  logic rready_i,
  output T     rdata_o
);

  // Write domain state
  logic       req_q;
  logic [1:0] ack_sync_q;
  logic       ack_seen;
  T           data_q;

  // Read domain state
  logic       ack_q;
  logic [1:0] req_sync_q;
  logic       req_seen;

  assign ack_seen = ack_sync_q[1];
  assign req_seen = req_sync_q[1];

  // Free only once request and acknowledge are both back at zero
  assign wready_o = !req_q && !ack_seen;

  always_ff @(posedge clk_wr_i or negedge rst_wr_ni) begin
    if (!rst_wr_ni) begin
      req_q      <= 1'b0;
      ack_sync_q <= '0;
    end else begin
      ack_sync_q <= {ack_sync_q[0], ack_q};
      if (wvalid_i && wready_o) begin
        req_q <= 1'b1;
      end else if (ack_seen) begin
        // Item taken on the far side, drop the request
        req_q <= 1'b0;
      end
    end
  end

  // Held steady until the handshake has fully returned to zero
  always_ff @(posedge clk_wr_i) begin
    if (wvalid_i && wready_o) begin
      data_q <= wdata_i;
    end
  end

  // Item visible from request seen until it is taken
  assign rvalid_o = req_seen && !ack_q;
  assign rdata_o  = data_q;

  always_ff @(posedge clk_rd_i or negedge rst_rd_ni) begin
    if (!rst_rd_ni) begin
      req_sync_q <= '0;
      ack_q      <= 1'b0;
    end else begin
      req_sync_q <= {req_sync_q[0], req_q};
      if (rvalid_o && rready_i) begin
        ack_q <= 1'b1;
      end else if (!req_seen) begin
        // Writer has seen the acknowledge, return to zero
        ack_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/dm_regs_pkg.sv ====
// Debug register file map
// DMI addresses of the data, scratch and ID registers
// Fixed value returned by the ID register
`default_nettype none

package dm_regs_pkg;

  // Data0 to data3 sit on consecutive addresses, low two bits pick the entry
  localparam logic [6:0] DM_ADDR_DATA0   = 7'h04;
  localparam logic [6:0] DM_ADDR_DATA1   = 7'h05;
  localparam logic [6:0] DM_ADDR_DATA2   = 7'h06;
  localparam logic [6:0] DM_ADDR_DATA3   = 7'h07;
  localparam logic [6:0] DM_ADDR_ID      = 7'h11;
  localparam logic [6:0] DM_ADDR_SCRATCH = 7'h20;

  // Read-only identification word
  localparam logic [31:0] DM_ID_VALUE = 32'h0dbe_0c01;

endpackage

`default_nettype wire

// ==== design/dmi_pkg.sv ====
// DMI transport definitions
// Address and data widths of a debug module interface access
// Op and status codes as carried on the DMI
// Packed request and response words that cross the clock domains
// Cycle budget the JTAG side grants the core for one access
`default_nettype none

package dmi_pkg;

  localparam int unsigned DMI_ADDR_W = 7;
  localparam int unsigned DMI_DATA_W = 32;

  // Tck cycles to wait for the core before answering busy
  localparam int unsigned DMI_TIMEOUT_CYCLES = 64;
  // Down-counter width, must hold the full budget
  localparam int unsigned DMI_TIMEOUT_W = $clog2(DMI_TIMEOUT_CYCLES + 1);

  typedef enum logic [1:0] {
    DMI_OP_NOP   = 2'h0,
    DMI_OP_READ  = 2'h1,
    DMI_OP_WRITE = 2'h2
  } dmi_op_e;

  // Code 1 is reserved by the debug spec
  typedef enum logic [1:0] {
    DMI_SUCCESS = 2'h0,
    DMI_FAILED  = 2'h2,
    DMI_BUSY    = 2'h3
  } dmi_status_e;

  typedef struct packed {
    logic [DMI_ADDR_W-1:0] addr;
    logic [DMI_DATA_W-1:0] data;
    dmi_op_e               op;
  } dmi_req_t;

  typedef struct packed {
    logic [DMI_DATA_W-1:0] data;
    dmi_status_e           status;
  } dmi_resp_t;

endpackage

`default_nettype wire
